//--- src/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus widths
`define DATA_W 32
`define ADDR_W 32

// Address map
`define SRAM_BASE 32'h0000_0000
`define SRAM_WORDS 1024
`define DMA_BASE 32'h1000_0000
`define WDT_BASE 32'h2000_0000

// Register windows span 16 bytes
`define REG_OFF_W 4

// Watchdog count after reset
`define WDT_RELOAD_DEF 32'h0000_ffff

`endif

//--- src/busPkg.sv
package busPkg;

	// Same encoding as the AXI response field
	typedef enum logic [1:0] {
		respOkay   = 2'b00,
		respSlvErr = 2'b10,
		respDecErr = 2'b11
	} busResp_e;

	// Target picked by the address decoder
	typedef enum logic [1:0] {
		selSram = 2'd0,
		selDma  = 2'd1,
		selWdt  = 2'd2,
		selNone = 2'd3
	} slaveSel_e;

endpackage

//--- src/periphPkg.sv
package periphPkg;

	// Copy engine states
	typedef enum logic [2:0] {
		dmaIdle      = 3'd0,
		dmaReadReq   = 3'd1,
		dmaReadResp  = 3'd2,
		dmaWriteReq  = 3'd3,
		dmaWriteResp = 3'd4,
		dmaDone      = 3'd5
	} dmaState_e;

	// DMA register offsets
	typedef enum logic [3:0] {
		regSrc  = 4'h0,
		regDst  = 4'h4,
		regLen  = 4'h8,
		regCtrl = 4'hc
	} dmaReg_e;

	// Watchdog register offsets
	typedef enum logic [3:0] {
		regEnable = 4'h0,
		regReload = 4'h4,
		regCount  = 4'h8
	} wdtReg_e;

endpackage

//--- src/busInterconnect.sv
`include "soc_macros.svh"

module busInterconnect import busPkg::*; (
	input  logic clk,
	input  logic arstN,
	// Host master
	input  logic hostReqValid,
	output logic hostReqReady,
	input  logic hostReqWrite,
	input  logic [`ADDR_W-1:0] hostReqAddr,
	input  logic [`DATA_W-1:0] hostReqWdata,
	output logic hostRespValid,
	input  logic hostRespReady,
	output logic [`DATA_W-1:0] hostRespRdata,
	output busResp_e hostResp,
	// DMA master
	input  logic dmaReqValid,
	output logic dmaReqReady,
	input  logic dmaReqWrite,
	input  logic [`ADDR_W-1:0] dmaReqAddr,
	input  logic [`DATA_W-1:0] dmaReqWdata,
	output logic dmaRespValid,
	input  logic dmaRespReady,
	output logic [`DATA_W-1:0] dmaRespRdata,
	output busResp_e dmaResp,
	// Shared request payload
	output logic slvReqWrite,
	output logic [`ADDR_W-1:0] slvReqAddr,
	output logic [`DATA_W-1:0] slvReqWdata,
	// SRAM
	output logic sramReqValid,
	input  logic sramReqReady,
	input  logic sramRespValid,
	output logic sramRespReady,
	input  logic [`DATA_W-1:0] sramRespRdata,
	input  busResp_e sramResp,
	// DMA registers
	output logic dmaRegReqValid,
	input  logic dmaRegReqReady,
	input  logic dmaRegRespValid,
	output logic dmaRegRespReady,
	input  logic [`DATA_W-1:0] dmaRegRespRdata,
	input  busResp_e dmaRegResp,
	// Watchdog
	output logic wdtReqValid,
	input  logic wdtReqReady,
	input  logic wdtRespValid,
	output logic wdtRespReady,
	input  logic [`DATA_W-1:0] wdtRespRdata,
	input  busResp_e wdtResp
);

	logic busy;
	logic grantDma;
	logic reqDone;
	logic rrDma;
	logic decRespValid;
	slaveSel_e target;
	logic mReqValid;
	logic mRespReady;
	logic pickDma;
	logic reqPhase;
	logic reqFire;
	logic respFire;
	logic selReqReady;
	logic selRespValid;
	logic [`DATA_W-1:0] selRdata;
	busResp_e selResp;

	function automatic slaveSel_e decode(input logic [`ADDR_W-1:0] addr);
		slaveSel_e sel;
		sel = selNone;
		if ((addr - `SRAM_BASE) < `ADDR_W'(`SRAM_WORDS * 4))
			sel = selSram;
		else if ((addr - `DMA_BASE) < (`ADDR_W'(1) << `REG_OFF_W))
			sel = selDma;
		else if ((addr - `WDT_BASE) < (`ADDR_W'(1) << `REG_OFF_W))
			sel = selWdt;
		return sel;
	endfunction

	// Round robin pointer favours the master not served last
	assign pickDma = dmaReqValid && (rrDma || !hostReqValid);

	assign mReqValid = grantDma ? dmaReqValid : hostReqValid;
	assign mRespReady = grantDma ? dmaRespReady : hostRespReady;
	assign slvReqWrite = grantDma ? dmaReqWrite : hostReqWrite;
	assign slvReqAddr = grantDma ? dmaReqAddr : hostReqAddr;
	assign slvReqWdata = grantDma ? dmaReqWdata : hostReqWdata;

	always_comb begin
		case (target)
			selSram: begin
				selReqReady = sramReqReady;
				selRespValid = sramRespValid;
				selRdata = sramRespRdata;
				selResp = sramResp;
			end
			selDma: begin
				selReqReady = dmaRegReqReady;
				selRespValid = dmaRegRespValid;
				selRdata = dmaRegRespRdata;
				selResp = dmaRegResp;
			end
			selWdt: begin
				selReqReady = wdtReqReady;
				selRespValid = wdtRespValid;
				selRdata = wdtRespRdata;
				selResp = wdtResp;
			end
			default: begin
				// Unmapped address answered locally
				selReqReady = 1'b1;
				selRespValid = decRespValid;
				selRdata = '0;
				selResp = respDecErr;
			end
		endcase
	end

	assign reqPhase = busy && !reqDone && mReqValid;
	assign reqFire = reqPhase && selReqReady;
	assign respFire = busy && selRespValid && mRespReady;

	assign sramReqValid = reqPhase && (target == selSram);
	assign dmaRegReqValid = reqPhase && (target == selDma);
	assign wdtReqValid = reqPhase && (target == selWdt);
	assign sramRespReady = busy && (target == selSram) && mRespReady;
	assign dmaRegRespReady = busy && (target == selDma) && mRespReady;
	assign wdtRespReady = busy && (target == selWdt) && mRespReady;

	assign hostReqReady = busy && !grantDma && !reqDone && selReqReady;
	assign dmaReqReady = busy && grantDma && !reqDone && selReqReady;
	assign hostRespValid = busy && !grantDma && selRespValid;
	assign dmaRespValid = busy && grantDma && selRespValid;
	assign hostRespRdata = selRdata;
	assign dmaRespRdata = selRdata;
	assign hostResp = selResp;
	assign dmaResp = selResp;

	// Grant held from acceptance to response handshake
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busy <= 1'b0;
			grantDma <= 1'b0;
			reqDone <= 1'b0;
			rrDma <= 1'b0;
			decRespValid <= 1'b0;
			target <= selNone;
		end else if (!busy) begin
			if (hostReqValid || dmaReqValid) begin
				busy <= 1'b1;
				grantDma <= pickDma;
				target <= decode(pickDma ? dmaReqAddr : hostReqAddr);
			end
		end else begin
			if (reqFire) begin
				reqDone <= 1'b1;
				decRespValid <= (target == selNone);
			end
			if (respFire) begin
				busy <= 1'b0;
				reqDone <= 1'b0;
				decRespValid <= 1'b0;
				rrDma <= !grantDma;
			end
		end
	end

endmodule

//--- src/sramSlave.sv
`include "soc_macros.svh"

module sramSlave import busPkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic reqValid,
	output logic reqReady,
	input  logic reqWrite,
	input  logic [`ADDR_W-1:0] reqAddr,
	input  logic [`DATA_W-1:0] reqWdata,
	output logic respValid,
	input  logic respReady,
	output logic [`DATA_W-1:0] respRdata,
	output busResp_e resp
);

	localparam int IdxW = $clog2(`SRAM_WORDS);

	logic [`DATA_W-1:0] mem [`SRAM_WORDS];
	logic [IdxW-1:0] wordIdx;
	logic reqFire;

	// Word addressing ignores the byte offset bits
	assign wordIdx = reqAddr[IdxW+1:2];
	assign reqReady = !respValid;
	assign reqFire = reqValid && reqReady;
	assign resp = respOkay;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			respValid <= 1'b0;
		else if (reqFire)
			respValid <= 1'b1;
		else if (respReady)
			respValid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reqFire) begin
			if (reqWrite)
				mem[wordIdx] <= reqWdata;
			respRdata <= reqWrite ? '0 : mem[wordIdx];
		end
	end

endmodule

//--- src/dmaEngine.sv
`include "soc_macros.svh"

module dmaEngine import busPkg::*, periphPkg::*; (
	input  logic clk,
	input  logic arstN,
	// Register slave
	input  logic reqValid,
	output logic reqReady,
	input  logic reqWrite,
	input  logic [`ADDR_W-1:0] reqAddr,
	input  logic [`DATA_W-1:0] reqWdata,
	output logic respValid,
	input  logic respReady,
	output logic [`DATA_W-1:0] respRdata,
	output busResp_e resp,
	// Copy master
	output logic mReqValid,
	input  logic mReqReady,
	output logic mReqWrite,
	output logic [`ADDR_W-1:0] mReqAddr,
	output logic [`DATA_W-1:0] mReqWdata,
	input  logic mRespValid,
	output logic mRespReady,
	input  logic [`DATA_W-1:0] mRespRdata,
	input  busResp_e mResp,
	output logic irq
);

	dmaState_e state;
	dmaReg_e regOff;
	logic [`ADDR_W-1:0] srcReg;
	logic [`ADDR_W-1:0] dstReg;
	logic [`DATA_W-1:0] lenReg;
	logic [`DATA_W-1:0] dataBuf;
	logic [`DATA_W-1:0] rdData;
	logic regErr;
	logic reqFire;
	logic busy;
	logic ctrlWrite;
	logic start;
	logic clearIrq;

	assign regOff = dmaReg_e'(reqAddr[`REG_OFF_W-1:0]);
	assign reqReady = !respValid;
	assign reqFire = reqValid && reqReady;
	assign busy = (state != dmaIdle);
	assign ctrlWrite = reqFire && reqWrite && (regOff == regCtrl);
	assign start = ctrlWrite && reqWdata[0];
	assign clearIrq = ctrlWrite && reqWdata[1];

	always_comb begin
		rdData = '0;
		regErr = 1'b0;
		case (regOff)
			regSrc: rdData = srcReg;
			regDst: rdData = dstReg;
			regLen: rdData = lenReg;
			regCtrl: rdData = {{(`DATA_W-2){1'b0}}, irq, busy};
			default: regErr = 1'b1;
		endcase
		// Setup registers locked while copying
		if (reqWrite && busy && regOff != regCtrl)
			regErr = 1'b1;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			respValid <= 1'b0;
			state <= dmaIdle;
			irq <= 1'b0;
			srcReg <= '0;
			dstReg <= '0;
			lenReg <= '0;
		end else begin
			if (respValid && respReady)
				respValid <= 1'b0;
			if (reqFire)
				respValid <= 1'b1;
			if (reqFire && reqWrite && !regErr) begin
				case (regOff)
					regSrc: srcReg <= reqWdata;
					regDst: dstReg <= reqWdata;
					regLen: lenReg <= reqWdata;
					default: ;
				endcase
			end
			if (clearIrq)
				irq <= 1'b0;
			case (state)
				dmaIdle:
					if (start)
						state <= (lenReg == '0) ? dmaDone : dmaReadReq;
				dmaReadReq:
					if (mReqReady)
						state <= dmaReadResp;
				dmaReadResp:
					if (mRespValid)
						state <= (mResp == respOkay) ? dmaWriteReq : dmaDone;
				dmaWriteReq:
					if (mReqReady)
						state <= dmaWriteResp;
				dmaWriteResp:
					if (mRespValid) begin
						// Step both pointers one word
						srcReg <= srcReg + `ADDR_W'(4);
						dstReg <= dstReg + `ADDR_W'(4);
						lenReg <= lenReg - `DATA_W'(1);
						if (mResp != respOkay || lenReg == `DATA_W'(1))
							state <= dmaDone;
						else
							state <= dmaReadReq;
					end
				dmaDone: begin
					state <= dmaIdle;
					irq <= 1'b1;
				end
				default: state <= dmaIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reqFire) begin
			respRdata <= reqWrite ? '0 : rdData;
			resp <= regErr ? respSlvErr : respOkay;
		end
		if (state == dmaReadResp && mRespValid)
			dataBuf <= mRespRdata;
	end

	assign mReqValid = (state == dmaReadReq) || (state == dmaWriteReq);
	assign mReqWrite = (state == dmaWriteReq);
	assign mReqAddr = mReqWrite ? dstReg : srcReg;
	assign mReqWdata = dataBuf;
	assign mRespReady = (state == dmaReadResp) || (state == dmaWriteResp);

endmodule

//--- src/watchdogSlave.sv
`include "soc_macros.svh"

module watchdogSlave import busPkg::*, periphPkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic reqValid,
	output logic reqReady,
	input  logic reqWrite,
	input  logic [`ADDR_W-1:0] reqAddr,
	input  logic [`DATA_W-1:0] reqWdata,
	output logic respValid,
	input  logic respReady,
	output logic [`DATA_W-1:0] respRdata,
	output busResp_e resp,
	output logic timeout
);

	wdtReg_e regOff;
	logic enable;
	logic [`DATA_W-1:0] count;
	logic [`DATA_W-1:0] rdData;
	logic regErr;
	logic reqFire;
	logic wrEnable;
	logic wrReload;

	assign regOff = wdtReg_e'(reqAddr[`REG_OFF_W-1:0]);
	assign reqReady = !respValid;
	assign reqFire = reqValid && reqReady;
	assign wrEnable = reqFire && reqWrite && (regOff == regEnable);
	assign wrReload = reqFire && reqWrite && (regOff == regReload);

	always_comb begin
		rdData = '0;
		regErr = 1'b0;
		case (regOff)
			regEnable: rdData = {{(`DATA_W-1){1'b0}}, enable};
			regReload: rdData = '0;
			// Counter is read only
			regCount: begin
				rdData = count;
				regErr = reqWrite;
			end
			default: regErr = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			respValid <= 1'b0;
			enable <= 1'b0;
			count <= `WDT_RELOAD_DEF;
			timeout <= 1'b0;
		end else begin
			if (respValid && respReady)
				respValid <= 1'b0;
			if (reqFire)
				respValid <= 1'b1;
			if (enable) begin
				if (count != '0)
					count <= count - `DATA_W'(1);
				else
					timeout <= 1'b1;
			end
			// Bus writes override the countdown
			if (wrEnable) begin
				enable <= reqWdata[0];
				if (!reqWdata[0])
					timeout <= 1'b0;
			end
			if (wrReload) begin
				count <= reqWdata;
				timeout <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reqFire) begin
			respRdata <= reqWrite ? '0 : rdData;
			resp <= regErr ? respSlvErr : respOkay;
		end
	end

endmodule

//--- src/socTop.sv
`include "soc_macros.svh"

module socTop import busPkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic hostReqValid,
	output logic hostReqReady,
	input  logic hostReqWrite,
	input  logic [`ADDR_W-1:0] hostReqAddr,
	input  logic [`DATA_W-1:0] hostReqWdata,
	output logic hostRespValid,
	input  logic hostRespReady,
	output logic [`DATA_W-1:0] hostRespRdata,
	output busResp_e hostResp,
	output logic dmaInterrupt,
	output logic wdtTimeout
);

	// DMA master link
	logic dmaReqValid;
	logic dmaReqReady;
	logic dmaReqWrite;
	logic [`ADDR_W-1:0] dmaReqAddr;
	logic [`DATA_W-1:0] dmaReqWdata;
	logic dmaRespValid;
	logic dmaRespReady;
	logic [`DATA_W-1:0] dmaRespRdata;
	busResp_e dmaResp;

	// Request payload seen by every slave
	logic slvReqWrite;
	logic [`ADDR_W-1:0] slvReqAddr;
	logic [`DATA_W-1:0] slvReqWdata;

	logic sramReqValid;
	logic sramReqReady;
	logic sramRespValid;
	logic sramRespReady;
	logic [`DATA_W-1:0] sramRespRdata;
	busResp_e sramResp;

	logic dmaRegReqValid;
	logic dmaRegReqReady;
	logic dmaRegRespValid;
	logic dmaRegRespReady;
	logic [`DATA_W-1:0] dmaRegRespRdata;
	busResp_e dmaRegResp;

	logic wdtReqValid;
	logic wdtReqReady;
	logic wdtRespValid;
	logic wdtRespReady;
	logic [`DATA_W-1:0] wdtRespRdata;
	busResp_e wdtResp;

	// Net names above match the interconnect ports
	busInterconnect xbar (.*);

	sramSlave sram (
		.clk(clk),
		.arstN(arstN),
		.reqValid(sramReqValid),
		.reqReady(sramReqReady),
		.reqWrite(slvReqWrite),
		.reqAddr(slvReqAddr),
		.reqWdata(slvReqWdata),
		.respValid(sramRespValid),
		.respReady(sramRespReady),
		.respRdata(sramRespRdata),
		.resp(sramResp)
	);

	dmaEngine dma (
		.clk(clk),
		.arstN(arstN),
		.reqValid(dmaRegReqValid),
		.reqReady(dmaRegReqReady),
		.reqWrite(slvReqWrite),
		.reqAddr(slvReqAddr),
		.reqWdata(slvReqWdata),
		.respValid(dmaRegRespValid),
		.respReady(dmaRegRespReady),
		.respRdata(dmaRegRespRdata),
		.resp(dmaRegResp),
		.mReqValid(dmaReqValid),
		.mReqReady(dmaReqReady),
		.mReqWrite(dmaReqWrite),
		.mReqAddr(dmaReqAddr),
		.mReqWdata(dmaReqWdata),
		.mRespValid(dmaRespValid),
		.mRespReady(dmaRespReady),
		.mRespRdata(dmaRespRdata),
		.mResp(dmaResp),
		.irq(dmaInterrupt)
	);

	watchdogSlave wdt (
		.clk(clk),
		.arstN(arstN),
		.reqValid(wdtReqValid),
		.reqReady(wdtReqReady),
		.reqWrite(slvReqWrite),
		.reqAddr(slvReqAddr),
		.reqWdata(slvReqWdata),
		.respValid(wdtRespValid),
		.respReady(wdtRespReady),
		.respRdata(wdtRespRdata),
		.resp(wdtResp),
		.timeout(wdtTimeout)
	);

endmodule

//--- verification/socTopTb.sv
`include "soc_macros.svh"

module socTopTb import busPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Register addresses from the address map
	localparam logic [`ADDR_W-1:0] dmaSrcAddr = `DMA_BASE + 32'h0;
	localparam logic [`ADDR_W-1:0] dmaDstAddr = `DMA_BASE + 32'h4;
	localparam logic [`ADDR_W-1:0] dmaLenAddr = `DMA_BASE + 32'h8;
	localparam logic [`ADDR_W-1:0] dmaCtrlAddr = `DMA_BASE + 32'hc;
	localparam logic [`ADDR_W-1:0] wdtEnableAddr = `WDT_BASE + 32'h0;
	localparam logic [`ADDR_W-1:0] wdtReloadAddr = `WDT_BASE + 32'h4;

	// Cycle limits of the wait loops
	localparam int reqWaitMax = 200;
	localparam int respWaitMax = 200;
	localparam int irqWaitMax = 5000;
	localparam int wdtWaitMax = 200;

	localparam int copyWords = 8;
	localparam int wdtReload = 20;

	logic clk = 1'b0;
	logic arstN;
	logic hostReqValid;
	logic hostReqReady;
	logic hostReqWrite;
	logic [`ADDR_W-1:0] hostReqAddr;
	logic [`DATA_W-1:0] hostReqWdata;
	logic hostRespValid;
	logic hostRespReady;
	logic [`DATA_W-1:0] hostRespRdata;
	busResp_e hostResp;
	logic dmaInterrupt;
	logic wdtTimeout;

	int seed;
	logic [`DATA_W-1:0] sramModel [256];
	logic [`DATA_W-1:0] srcWords [copyWords];

	socTop socTop_inst (.*);

	always #2 clk = ~clk;

	task automatic failTimeout(input string what);
		$display("Timeout: %s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [`DATA_W-1:0] exp,
		input logic [`DATA_W-1:0] act);
		assert (act === exp) else begin
			$display("Mismatch in %s: expected %h, actual %h", name, exp, act);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		assert (act === exp) else begin
			$display("Mismatch in %s: expected %b, actual %b", name, exp, act);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic checkResp(input string name, input busResp_e exp, input busResp_e act);
		assert (act === exp) else begin
			$display("Mismatch in %s: expected %s, actual %s", name, exp.name(), act.name());
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	// One host transfer that returns at the falling edge after the response handshake
	task automatic hostAccess(input logic write, input logic [`ADDR_W-1:0] addr,
		input logic [`DATA_W-1:0] wdata, input logic stall,
		output logic [`DATA_W-1:0] rdata, output busResp_e resp);
		int cycles;
		logic done;
		@(negedge clk);
		hostReqValid = 1'b1;
		hostReqWrite = write;
		hostReqAddr = addr;
		hostReqWdata = wdata;
		cycles = 0;
		done = 1'b0;
		while (!done) begin
			#1;
			if (hostReqReady) begin
				done = 1'b1;
			end else begin
				cycles++;
				assert (cycles < reqWaitMax) else
					failTimeout($sformatf("host request to %h was never accepted", addr));
				@(negedge clk);
			end
		end
		// Request handshake on the rising edge in between
		@(negedge clk);
		hostReqValid = 1'b0;
		cycles = 0;
		done = 1'b0;
		while (!done) begin
			hostRespReady = !stall || (($random(seed) & 3) != 0);
			#1;
			if (hostRespValid && hostRespReady) begin
				rdata = hostRespRdata;
				resp = hostResp;
				done = 1'b1;
			end else begin
				cycles++;
				assert (cycles < respWaitMax) else
					failTimeout($sformatf("no response came for host access to %h", addr));
				@(negedge clk);
			end
		end
		@(negedge clk);
		hostRespReady = 1'b0;
	endtask

	task automatic hostWrite(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] wdata,
		input logic stall, output busResp_e resp);
		logic [`DATA_W-1:0] unused;
		hostAccess(1'b1, addr, wdata, stall, unused, resp);
	endtask

	task automatic hostRead(input logic [`ADDR_W-1:0] addr, input logic stall,
		output logic [`DATA_W-1:0] rdata, output busResp_e resp);
		hostAccess(1'b0, addr, '0, stall, rdata, resp);
	endtask

	task automatic sramTest();
		int addrQ[$];
		int idx;
		logic [`DATA_W-1:0] wdata;
		logic [`DATA_W-1:0] rdata;
		busResp_e resp;
		for (int i = 0; i < 16; i++) begin
			idx = $random(seed) & 32'hff;
			wdata = $random(seed);
			hostWrite(`SRAM_BASE + 32'(idx * 4), wdata, 1'b1, resp);
			checkResp("sram write resp", respOkay, resp);
			sramModel[idx] = wdata;
			addrQ.push_back(idx);
		end
		// Repeated indices read back the last value written
		foreach (addrQ[i]) begin
			hostRead(`SRAM_BASE + 32'(addrQ[i] * 4), 1'b1, rdata, resp);
			checkResp("sram read resp", respOkay, resp);
			checkValue("sram read data", sramModel[addrQ[i]], rdata);
		end
	endtask

	task automatic decodeErrTest();
		logic [`DATA_W-1:0] rdata;
		busResp_e resp;
		hostRead(32'h3000_0000, 1'b1, rdata, resp);
		checkResp("unmapped read resp", respDecErr, resp);
		checkValue("unmapped read data", '0, rdata);
		// Hole between the SRAM and the DMA window
		hostWrite(32'h0000_2000, 32'hdead_beef, 1'b1, resp);
		checkResp("unmapped write resp", respDecErr, resp);
	endtask

	task automatic dmaCopyTest();
		logic [`DATA_W-1:0] rdata;
		busResp_e resp;
		int cycles;
		for (int i = 0; i < copyWords; i++) begin
			srcWords[i] = $random(seed);
			hostWrite(32'h0000_0800 + 32'(i * 4), srcWords[i], 1'b1, resp);
			checkResp("dma source fill", respOkay, resp);
		end
		hostWrite(dmaSrcAddr, 32'h0000_0800, 1'b1, resp);
		checkResp("dma src write", respOkay, resp);
		hostWrite(dmaDstAddr, 32'h0000_0c00, 1'b1, resp);
		checkResp("dma dst write", respOkay, resp);
		hostWrite(dmaLenAddr, copyWords, 1'b1, resp);
		checkResp("dma len write", respOkay, resp);
		hostWrite(dmaCtrlAddr, 32'h1, 1'b1, resp);
		checkResp("dma start", respOkay, resp);

		// Busy set and interrupt still low
		hostRead(dmaCtrlAddr, 1'b1, rdata, resp);
		checkResp("dma busy read resp", respOkay, resp);
		checkValue("dma busy status", 32'h1, rdata);
		hostWrite(dmaLenAddr, 32'h4, 1'b1, resp);
		checkResp("dma len write while busy", respSlvErr, resp);

		cycles = 0;
		while (!dmaInterrupt) begin
			cycles++;
			assert (cycles < irqWaitMax) else
				failTimeout("dmaInterrupt did not rise after the copy was started");
			@(negedge clk);
		end

		for (int i = 0; i < copyWords; i++) begin
			hostRead(32'h0000_0c00 + 32'(i * 4), 1'b1, rdata, resp);
			checkResp("dma dest read resp", respOkay, resp);
			checkValue("dma dest word", srcWords[i], rdata);
		end
		hostRead(dmaCtrlAddr, 1'b1, rdata, resp);
		checkResp("dma done read resp", respOkay, resp);
		checkValue("dma done status", 32'h2, rdata);
		hostWrite(dmaCtrlAddr, 32'h2, 1'b1, resp);
		checkResp("dma irq clear resp", respOkay, resp);
		checkBit("dma irq after clear", 1'b0, dmaInterrupt);
	endtask

	task automatic watchdogTest();
		busResp_e resp;
		int cycles;
		hostWrite(wdtEnableAddr, 32'h1, 1'b1, resp);
		checkResp("wdt enable resp", respOkay, resp);
		// No stall so the count starts one cycle before the response handshake
		hostWrite(wdtReloadAddr, wdtReload, 1'b0, resp);
		checkResp("wdt reload resp", respOkay, resp);
		for (int i = 0; i < wdtReload; i++) begin
			checkBit("wdt timeout too early", 1'b0, wdtTimeout);
			@(negedge clk);
		end
		cycles = 0;
		while (!wdtTimeout) begin
			cycles++;
			assert (cycles < wdtWaitMax) else
				failTimeout("wdtTimeout did not rise after the reload count ran out");
			@(negedge clk);
		end
		hostWrite(wdtReloadAddr, 32'h0000_1000, 1'b1, resp);
		checkResp("wdt second reload resp", respOkay, resp);
		checkBit("wdt timeout after reload", 1'b0, wdtTimeout);
		hostWrite(wdtEnableAddr, 32'h0, 1'b1, resp);
		checkResp("wdt disable resp", respOkay, resp);
	endtask

	initial begin
		seed = 32'hc552_f3e0;
		arstN = 1'b0;
		hostReqValid = 1'b0;
		hostReqWrite = 1'b0;
		hostReqAddr = '0;
		hostReqWdata = '0;
		hostRespReady = 1'b0;
		repeat (10) @(negedge clk);
		arstN = 1'b1;

		checkBit("reset hostRespValid", 1'b0, hostRespValid);
		checkBit("reset dmaInterrupt", 1'b0, dmaInterrupt);
		checkBit("reset wdtTimeout", 1'b0, wdtTimeout);

		sramTest();
		decodeErrTest();
		dmaCopyTest();
		watchdogTest();

		$display("Regression passed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+src
src/busPkg.sv
src/periphPkg.sv
src/busInterconnect.sv
src/sramSlave.sv
src/dmaEngine.sv
src/watchdogSlave.sv
src/socTop.sv
verification/socTopTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it.
# The simulator exit status is the pass or fail result.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f vlog.f --top-module socTopTb -o socTopSim

./obj_dir/socTopSim
